// ==== door_lock_top.f ====
common/lock_pkg.sv
design/code_entry.sv
design/code_store.sv
design/lock_timer.sv
design/lock_ctrl.sv
display/seg_display.sv
design/door_lock_top.sv
tests/door_lock_chk.sv
tests/tb_clk_gen.sv
tests/tb_door_lock.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_door_lock \
	-f door_lock_top.f -o sim_door_lock

./obj_dir/sim_door_lock | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// ==== tests/tb_door_lock.sv ====
module tb_door_lock;

	timeunit 1ns;
	timeprecision 100ps;

	logic new_clk;
	logic rst1;
	logic enter;
	logic clear;
	logic change;
	logic [3:0] digit_sw;
	logic is_open;
	logic lockout;
	logic [6:0] seg;
	logic [3:0] an;

	integer seed;
	int errors;
	int err_at_start;
	int tests_run;
	int tests_failed;
	int timeouts;
	logic [15:0] stored_code;
	logic [15:0] new_code;
	logic [15:0] wrong_code;
	int exp_disp [4];
	int cnt;

	tb_clk_gen u_clk (.new_clk(new_clk), .rst1(rst1));

	door_lock_top uut
	(
		.new_clk  (new_clk),
		.rst1     (rst1),
		.enter    (enter),
		.clear    (clear),
		.change   (change),
		.digit_sw (digit_sw),
		.is_open  (is_open),
		.lockout  (lockout),
		.seg      (seg),
		.an       (an)
	);

	task automatic check_val(input string name, input int exp, input int act);
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic begin_test();
		err_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (errors == err_at_start)
			$display("test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	// active low segments {g,f,e,d,c,b,a}
	function automatic logic [6:0] seg_of(input int g);
		logic [6:0] hex_tab [16];
		hex_tab = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
		if (g < 16)
			return hex_tab[g];
		case (g)
			lock_pkg::GL_DASH: return 7'h3f;
			lock_pkg::GL_O: return 7'h40;
			lock_pkg::GL_P: return 7'h0c;
			lock_pkg::GL_E: return 7'h06;
			lock_pkg::GL_N: return 7'h2b;
			lock_pkg::GL_C: return 7'h46;
			lock_pkg::GL_L: return 7'h47;
			lock_pkg::GL_S: return 7'h12;
			lock_pkg::GL_D: return 7'h21;
			default: return 7'h7f;
		endcase
	endfunction

	////////////////////
	// button presses, each followed by an idle cycle
	task automatic press(input int which, input logic [3:0] d);
		digit_sw = d;
		enter = (which == 0);
		clear = (which == 1);
		change = (which == 2);
		@(negedge new_clk);
		enter = 1'b0;
		clear = 1'b0;
		change = 1'b0;
		@(negedge new_clk);
	endtask

	task automatic enter_code(input logic [15:0] c);
		for (int i = 0; i < 4; i++)
			press(0, c[15-4*i -: 4]);
	endtask

	// scan two full rounds and compare every lit position
	task automatic check_display(input string name);
		int pos;
		for (int k = 0; k < 8 * lock_pkg::SCAN_CYCLES; k++)
		begin
			@(negedge new_clk);
			case (an)
				4'b1110: pos = 0;
				4'b1101: pos = 1;
				4'b1011: pos = 2;
				4'b0111: pos = 3;
				default: pos = -1;
			endcase
			if (pos < 0)
			begin
				errors++;
				$display("%s: an selects no single digit", name);
			end
			else
				check_val(name, seg_of(exp_disp[pos]), seg);
		end
	endtask

	task automatic set_disp(input int a, input int b, input int c, input int d);
		exp_disp = '{a, b, c, d};
	endtask

	// resting closed shows C at position 0
	task automatic wait_closed_glyph(input int limit);
		int n;
		n = 0;
		while (!(an == 4'b1110 && seg == seg_of(lock_pkg::GL_C)) && n < limit)
		begin
			@(negedge new_clk);
			n++;
		end
		if (!(an == 4'b1110 && seg == seg_of(lock_pkg::GL_C)))
		begin
			timeouts++;
			$display("timeout: lock did not return to the closed display");
		end
	endtask

	task automatic open_and_relock(input string name, input logic [15:0] c);
		enter_code(c);
		check_val({name, " open"}, 1, is_open);
		press(0, 4'h0);
		check_val({name, " relock"}, 0, is_open);
	endtask

	initial
	begin
		seed = 54978;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timeouts = 0;
		enter = 1'b0;
		clear = 1'b0;
		change = 1'b0;
		digit_sw = 4'h0;
		stored_code = lock_pkg::RESET_CODE;

		cnt = 0;
		while (rst1 !== 1'b0 && cnt < 20)
		begin
			@(negedge new_clk);
			cnt++;
		end
		if (rst1 !== 1'b0)
		begin
			timeouts++;
			$display("timeout: reset never released");
		end

		begin_test();
		check_val("reset an", 4'b1110, an);
		check_val("reset is_open", 0, is_open);
		check_val("reset lockout", 0, lockout);
		set_disp(lock_pkg::GL_C, lock_pkg::GL_L, lock_pkg::GL_S, lock_pkg::GL_D);
		check_display("closed display");
		end_test("reset");

		////////////////////
		// unlock and relock
		begin_test();
		enter_code(stored_code);
		check_val("unlock is_open", 1, is_open);
		set_disp(lock_pkg::GL_O, lock_pkg::GL_P, lock_pkg::GL_E, lock_pkg::GL_N);
		check_display("open display");
		press(0, 4'h0);
		check_val("relock is_open", 0, is_open);
		end_test("unlock");

		////////////////////
		// wrong codes and lockout
		begin_test();
		for (int t = 1; t <= lock_pkg::MAX_TRIES; t++)
		begin
			wrong_code = 16'($random(seed));
			if (wrong_code == stored_code)
				wrong_code = ~wrong_code;
			enter_code(wrong_code);
			check_val("wrong code is_open", 0, is_open);
			check_val("wrong code lockout", (t == lock_pkg::MAX_TRIES), lockout);
		end
		cnt = 1;
		while (lockout && cnt < 2 * lock_pkg::LOCKOUT_CYCLES)
		begin
			// stray presses must change nothing
			enter = !enter && ($random(seed) & 1);
			digit_sw = 4'($random(seed));
			@(negedge new_clk);
			if (lockout)
			begin
				cnt++;
				check_val("lockout display", seg_of(lock_pkg::GL_DASH), seg);
			end
		end
		enter = 1'b0;
		if (lockout)
		begin
			timeouts++;
			$display("timeout: lockout never ended");
		end
		check_val("lockout cycles", lock_pkg::LOCKOUT_CYCLES, cnt);
		open_and_relock("after lockout", stored_code);
		end_test("lockout");

		////////////////////
		// code change, good then bad old code
		begin_test();
		enter_code(stored_code);
		press(2, 4'h0);
		new_code = 16'($random(seed));
		enter_code(stored_code);
		enter_code(new_code);
		check_val("change closes", 0, is_open);
		stored_code = new_code;
		open_and_relock("new code", stored_code);
		enter_code(stored_code);
		press(2, 4'h0);
		wrong_code = 16'($random(seed));
		if (wrong_code == stored_code)
			wrong_code = ~wrong_code;
		enter_code(wrong_code);
		enter_code(16'($random(seed)));
		check_val("bad change stays open", 1, is_open);
		press(0, 4'h0);
		open_and_relock("old code kept", stored_code);
		end_test("code change");

		////////////////////
		// clear and idle timeout
		begin_test();
		press(0, 4'($random(seed)));
		press(0, 4'($random(seed)));
		press(1, 4'h0);
		open_and_relock("after clear", stored_code);
		press(0, 4'($random(seed)));
		press(0, 4'($random(seed)));
		wait_closed_glyph(lock_pkg::IDLE_CYCLES + 20);
		open_and_relock("after idle", stored_code);
		end_test("clear and idle");

		////////////////////
		// entry display with live switch digit
		begin_test();
		press(0, 4'($random(seed)));
		press(0, 4'($random(seed)));
		digit_sw = 4'($random(seed));
		set_disp(lock_pkg::GL_DASH, lock_pkg::GL_DASH, digit_sw, lock_pkg::GL_BLANK);
		check_display("entry display");
		press(1, 4'h0);
		wait_closed_glyph(lock_pkg::IDLE_CYCLES + 20);
		end_test("display scan");

		$display("tests %0d, failed %0d, errors %0d, timeouts %0d",
			tests_run, tests_failed, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen
(
	output logic new_clk,
	output logic rst1
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		new_clk = 1'b0;
		forever
			#50 new_clk = ~new_clk;
	end

	// reset held for five rising edges
	initial
	begin
		rst1 = 1'b1;
		repeat (5) @(posedge new_clk);
		@(negedge new_clk);
		rst1 = 1'b0;
	end

endmodule

// ==== tests/door_lock_chk.sv ====
module door_lock_chk
(
	input logic       new_clk,
	input logic       rst1,
	input logic       enter,
	input logic       is_open,
	input logic       lockout,
	input logic [3:0] an
);

	timeunit 1ns;
	timeprecision 100ps;

	// open and lockout exclude each other
	open_not_locked: assert property (@(posedge new_clk) disable iff (rst1)
		!(is_open && lockout))
		else $error("is_open and lockout high together");

	// one digit lit at a time
	one_anode: assert property (@(posedge new_clk) disable iff (rst1)
		$onehot(~an))
		else $error("an does not select exactly one digit");

	// opening follows the last digit by two edges
	open_after_enter: assert property (@(posedge new_clk) disable iff (rst1)
		$rose(is_open) |-> $past(enter, 2))
		else $error("is_open rose without an enter two cycles earlier");

endmodule

bind door_lock_top door_lock_chk u_chk
(
	.new_clk (new_clk),
	.rst1    (rst1),
	.enter   (enter),
	.is_open (is_open),
	.lockout (lockout),
	.an      (an)
);

// ==== design/door_lock_top.sv ====
module door_lock_top
(
	input  logic                         new_clk,
	input  logic                         rst1,
	input  logic                         enter,
	input  logic                         clear,
	input  logic                         change,
	input  logic [lock_pkg::DIGIT_W-1:0] digit_sw,
	output logic                         is_open,
	output logic                         lockout,
	output logic [6:0]                   seg,
	output logic [lock_pkg::NUM_DIGITS-1:0] an
);

	logic shift_en;
	logic entry_clr;
	logic save_old;
	logic check_en;
	logic store_en;
	logic idle_restart;
	logic lockout_start;
	logic code_match;
	logic old_ok;
	logic timer_done;
	logic [2:0] entry_count;
	logic [lock_pkg::CODE_W-1:0] entry_code;
	logic [lock_pkg::STATE_W-1:0] state;

	lock_ctrl u_ctrl
	(
		.new_clk       (new_clk),
		.rst1          (rst1),
		.enter         (enter),
		.clear         (clear),
		.change        (change),
		.entry_count   (entry_count),
		.code_match    (code_match),
		.old_ok        (old_ok),
		.timer_done    (timer_done),
		.shift_en      (shift_en),
		.entry_clr     (entry_clr),
		.save_old      (save_old),
		.check_en      (check_en),
		.store_en      (store_en),
		.idle_restart  (idle_restart),
		.lockout_start (lockout_start),
		.is_open       (is_open),
		.lockout       (lockout),
		.state         (state)
	);

	code_entry u_entry
	(
		.new_clk     (new_clk),
		.rst1        (rst1),
		.shift_en    (shift_en),
		.entry_clr   (entry_clr),
		.digit_sw    (digit_sw),
		.entry_code  (entry_code),
		.entry_count (entry_count)
	);

	code_store u_store
	(
		.new_clk    (new_clk),
		.rst1       (rst1),
		.save_old   (save_old),
		.check_en   (check_en),
		.store_en   (store_en),
		.entry_code (entry_code),
		.code_match (code_match),
		.old_ok     (old_ok)
	);

	lock_timer u_timer
	(
		.new_clk       (new_clk),
		.rst1          (rst1),
		.enter         (enter),
		.clear         (clear),
		.change        (change),
		.idle_restart  (idle_restart),
		.lockout_start (lockout_start),
		.timer_done    (timer_done)
	);

	seg_display u_disp
	(
		.new_clk     (new_clk),
		.rst1        (rst1),
		.state       (state),
		.entry_count (entry_count),
		.digit_sw    (digit_sw),
		.seg         (seg),
		.an          (an)
	);

endmodule

// ==== display/seg_display.sv ====
module seg_display
(
	input  logic                            new_clk,
	input  logic                            rst1,
	input  logic [lock_pkg::STATE_W-1:0]    state,
	input  logic [2:0]                      entry_count,
	input  logic [lock_pkg::DIGIT_W-1:0]    digit_sw,
	output logic [6:0]                      seg,
	output logic [lock_pkg::NUM_DIGITS-1:0] an
);

	logic [lock_pkg::DISP_W-1:0] disp [lock_pkg::NUM_DIGITS];
	logic [lock_pkg::DISP_W-1:0] cur;
	logic [lock_pkg::SCAN_W-1:0] scan_div;
	logic [lock_pkg::POS_W-1:0] scan_pos;

	////////////////////
	// codes per position, 0 is leftmost
	always_comb
	begin
		// entry phases: dashes, live digit, blanks
		for (int i = 0; i < lock_pkg::NUM_DIGITS; i++)
		begin
			if (3'(i) < entry_count)
				disp[i] = lock_pkg::GL_DASH;
			else if (3'(i) == entry_count)
				disp[i] = {1'b0, digit_sw};
			else
				disp[i] = lock_pkg::GL_BLANK;
		end
		case (state)
			lock_pkg::ST_CLOSED:
			begin
				disp[0] = lock_pkg::GL_C;
				disp[1] = lock_pkg::GL_L;
				disp[2] = lock_pkg::GL_S;
				disp[3] = lock_pkg::GL_D;
			end
			lock_pkg::ST_OPEN:
			begin
				disp[0] = lock_pkg::GL_O;
				disp[1] = lock_pkg::GL_P;
				disp[2] = lock_pkg::GL_E;
				disp[3] = lock_pkg::GL_N;
			end
			lock_pkg::ST_LOCKOUT:
			begin
				for (int i = 0; i < lock_pkg::NUM_DIGITS; i++)
					disp[i] = lock_pkg::GL_DASH;
			end
			default:
			begin
			end
		endcase
	end

	////////////////////
	// free-running scan
	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
		begin
			scan_div <= '0;
			scan_pos <= '0;
		end
		else if ({1'b0, scan_div} == lock_pkg::SCAN_CYCLES - 1'b1)
		begin
			scan_div <= '0;
			scan_pos <= scan_pos + 1'b1;
		end
		else
			scan_div <= scan_div + 1'b1;
	end

	assign an = ~({{(lock_pkg::NUM_DIGITS - 1){1'b0}}, 1'b1} << scan_pos);
	assign cur = disp[scan_pos];

	// seg is {g,f,e,d,c,b,a}, low lights a segment
	always_comb
	begin
		case (cur)
			5'd0: seg = 7'h40;
			5'd1: seg = 7'h79;
			5'd2: seg = 7'h24;
			5'd3: seg = 7'h30;
			5'd4: seg = 7'h19;
			5'd5: seg = 7'h12;
			5'd6: seg = 7'h02;
			5'd7: seg = 7'h78;
			5'd8: seg = 7'h00;
			5'd9: seg = 7'h10;
			5'd10: seg = 7'h08;
			5'd11: seg = 7'h03;
			5'd12: seg = 7'h46;
			5'd13: seg = 7'h21;
			5'd14: seg = 7'h06;
			5'd15: seg = 7'h0e;
			lock_pkg::GL_DASH: seg = 7'h3f;
			lock_pkg::GL_O: seg = 7'h40;
			lock_pkg::GL_P: seg = 7'h0c;
			lock_pkg::GL_E: seg = 7'h06;
			lock_pkg::GL_N: seg = 7'h2b;
			lock_pkg::GL_C: seg = 7'h46;
			lock_pkg::GL_L: seg = 7'h47;
			lock_pkg::GL_S: seg = 7'h12;
			lock_pkg::GL_D: seg = 7'h21;
			// GL_BLANK and unused codes
			default: seg = 7'h7f;
		endcase
	end

endmodule

// ==== design/lock_ctrl.sv ====
module lock_ctrl
(
	input  logic                         new_clk,
	input  logic                         rst1,
	input  logic                         enter,
	input  logic                         clear,
	input  logic                         change,
	input  logic [2:0]                   entry_count,
	input  logic                         code_match,
	input  logic                         old_ok,
	input  logic                         timer_done,
	output logic                         shift_en,
	output logic                         entry_clr,
	output logic                         save_old,
	output logic                         check_en,
	output logic                         store_en,
	output logic                         idle_restart,
	output logic                         lockout_start,
	output logic                         is_open,
	output logic                         lockout,
	output logic [lock_pkg::STATE_W-1:0] state
);

	logic [lock_pkg::STATE_W-1:0] state_nx;
	logic [lock_pkg::TRY_W-1:0] tries;
	logic last_digit;
	logic phase_full;

	assign last_digit = (entry_count == 3'(lock_pkg::NUM_DIGITS - 1));
	assign phase_full = (entry_count == 3'(lock_pkg::NUM_DIGITS));

	////////////////////
	// next state and datapath strobes
	always_comb
	begin
		state_nx = state;
		shift_en = 1'b0;
		entry_clr = 1'b0;
		save_old = 1'b0;
		check_en = 1'b0;
		store_en = 1'b0;
		idle_restart = 1'b0;
		lockout_start = 1'b0;
		case (state)
			lock_pkg::ST_CLOSED:
			begin
				// first press is already digit one
				if (enter)
				begin
					shift_en = 1'b1;
					state_nx = lock_pkg::ST_ENTRY;
				end
			end
			lock_pkg::ST_ENTRY:
			begin
				if (enter)
				begin
					shift_en = 1'b1;
					if (last_digit)
						state_nx = lock_pkg::ST_CHECK;
				end
				else if (clear)
					entry_clr = 1'b1;
				else if (timer_done)
				begin
					entry_clr = 1'b1;
					state_nx = lock_pkg::ST_CLOSED;
				end
			end
			lock_pkg::ST_CHECK:
			begin
				check_en = 1'b1;
				entry_clr = 1'b1;
				if (code_match)
					state_nx = lock_pkg::ST_OPEN;
				else if (tries == lock_pkg::MAX_TRIES - 1'b1)
				begin
					lockout_start = 1'b1;
					state_nx = lock_pkg::ST_LOCKOUT;
				end
				else
					state_nx = lock_pkg::ST_CLOSED;
			end
			lock_pkg::ST_OPEN:
			begin
				if (enter)
					state_nx = lock_pkg::ST_CLOSED;
				else if (change)
				begin
					entry_clr = 1'b1;
					state_nx = lock_pkg::ST_OLD;
				end
			end
			lock_pkg::ST_OLD:
			begin
				// one cycle after the fourth old digit
				if (phase_full)
				begin
					save_old = 1'b1;
					entry_clr = 1'b1;
					state_nx = lock_pkg::ST_NEW;
				end
				else if (enter)
					shift_en = 1'b1;
				else if (clear)
					entry_clr = 1'b1;
				else if (timer_done)
				begin
					entry_clr = 1'b1;
					state_nx = lock_pkg::ST_OPEN;
				end
			end
			lock_pkg::ST_NEW:
			begin
				if (enter)
				begin
					shift_en = 1'b1;
					if (last_digit)
						state_nx = lock_pkg::ST_CHANGE;
				end
				else if (clear)
					entry_clr = 1'b1;
				else if (timer_done)
				begin
					entry_clr = 1'b1;
					state_nx = lock_pkg::ST_OPEN;
				end
			end
			lock_pkg::ST_CHANGE:
			begin
				store_en = 1'b1;
				entry_clr = 1'b1;
				state_nx = old_ok ? lock_pkg::ST_CLOSED : lock_pkg::ST_OPEN;
			end
			lock_pkg::ST_LOCKOUT:
			begin
				if (timer_done)
				begin
					idle_restart = 1'b1;
					state_nx = lock_pkg::ST_CLOSED;
				end
			end
			default:
				state_nx = lock_pkg::ST_CLOSED;
		endcase
	end

	////////////////////
	// state, outputs, try counter
	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
		begin
			state <= lock_pkg::ST_CLOSED;
			is_open <= 1'b0;
			lockout <= 1'b0;
			tries <= '0;
		end
		else
		begin
			state <= state_nx;
			// the door stays open through a code change
			is_open <= (state_nx == lock_pkg::ST_OPEN) || (state_nx == lock_pkg::ST_OLD) ||
				(state_nx == lock_pkg::ST_NEW) || (state_nx == lock_pkg::ST_CHANGE);
			lockout <= (state_nx == lock_pkg::ST_LOCKOUT);
			if (state == lock_pkg::ST_CHECK)
				tries <= code_match ? '0 : tries + 1'b1;
			else if (state == lock_pkg::ST_LOCKOUT && timer_done)
				tries <= '0;
		end
	end

endmodule

// ==== design/lock_timer.sv ====
module lock_timer
(
	input  logic new_clk,
	input  logic rst1,
	input  logic enter,
	input  logic clear,
	input  logic change,
	input  logic idle_restart,
	input  logic lockout_start,
	output logic timer_done
);

	logic [lock_pkg::TIMER_W-1:0] count;
	logic lock_mode;
	logic press;

	assign press = enter || clear || change;
	assign timer_done = (count == '0);

	// counts down to zero, done holds there
	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
		begin
			count <= lock_pkg::IDLE_CYCLES - 1'b1;
			lock_mode <= 1'b0;
		end
		else if (lockout_start)
		begin
			count <= lock_pkg::LOCKOUT_CYCLES - 1'b1;
			lock_mode <= 1'b1;
		end
		else if (idle_restart)
		begin
			count <= lock_pkg::IDLE_CYCLES - 1'b1;
			lock_mode <= 1'b0;
		end
		// presses must not stretch or cut the lockout
		else if (press && !lock_mode)
			count <= lock_pkg::IDLE_CYCLES - 1'b1;
		else if (!timer_done)
			count <= count - 1'b1;
	end

endmodule

// ==== design/code_store.sv ====
module code_store
(
	input  logic                        new_clk,
	input  logic                        rst1,
	input  logic                        save_old,
	input  logic                        check_en,
	input  logic                        store_en,
	input  logic [lock_pkg::CODE_W-1:0] entry_code,
	output logic                        code_match,
	output logic                        old_ok
);

	logic [lock_pkg::CODE_W-1:0] stored_code;
	logic code_eq;

	assign code_eq = (entry_code == stored_code);

	// only meaningful while the fsm checks
	assign code_match = check_en && code_eq;

	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
		begin
			stored_code <= lock_pkg::RESET_CODE;
			old_ok <= 1'b0;
		end
		else
		begin
			if (save_old)
				old_ok <= code_eq;
			// new code only after a good old code
			if (store_en && old_ok)
				stored_code <= entry_code;
		end
	end

endmodule

// ==== design/code_entry.sv ====
module code_entry
(
	input  logic                         new_clk,
	input  logic                         rst1,
	input  logic                         shift_en,
	input  logic                         entry_clr,
	input  logic [lock_pkg::DIGIT_W-1:0] digit_sw,
	output logic [lock_pkg::CODE_W-1:0]  entry_code,
	output logic [2:0]                   entry_count
);

	logic count_full;

	assign count_full = (entry_count == 3'(lock_pkg::NUM_DIGITS));

	// digits in this phase, 0 to 4
	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
			entry_count <= '0;
		else if (entry_clr)
			entry_count <= '0;
		else if (shift_en && !count_full)
			entry_count <= entry_count + 1'b1;
	end

	// first digit ends up in the top nibble
	always_ff @(posedge new_clk or posedge rst1)
	begin
		if (rst1)
			entry_code <= '0;
		else if (entry_clr)
			entry_code <= '0;
		else if (shift_en && !count_full)
			entry_code <= {entry_code[lock_pkg::CODE_W-lock_pkg::DIGIT_W-1:0], digit_sw};
	end

endmodule

// ==== common/lock_pkg.sv ====
package lock_pkg;

	////////////////////
	// widths and counts
	localparam int DIGIT_W = 4;
	localparam int NUM_DIGITS = 4;
	localparam int CODE_W = DIGIT_W * NUM_DIGITS;
	localparam int POS_W = 2;
	localparam int TRY_W = 2;

	////////////////////
	// reset code and timing
	localparam logic [CODE_W-1:0] RESET_CODE = 16'h1234;
	localparam logic [TRY_W-1:0] MAX_TRIES = 2'd3;

	localparam int TIMER_W = 8;
	localparam logic [TIMER_W-1:0] IDLE_CYCLES = 8'd200;
	localparam logic [TIMER_W-1:0] LOCKOUT_CYCLES = 8'd64;

	// one extra bit so the count itself fits
	localparam int SCAN_W = 2;
	localparam logic [SCAN_W:0] SCAN_CYCLES = 3'd4;

	////////////////////
	// fsm states
	localparam int STATE_W = 4;
	localparam logic [STATE_W-1:0] ST_CLOSED = 4'd0;
	localparam logic [STATE_W-1:0] ST_ENTRY = 4'd1;
	localparam logic [STATE_W-1:0] ST_CHECK = 4'd2;
	localparam logic [STATE_W-1:0] ST_OPEN = 4'd3;
	localparam logic [STATE_W-1:0] ST_OLD = 4'd4;
	localparam logic [STATE_W-1:0] ST_NEW = 4'd5;
	localparam logic [STATE_W-1:0] ST_CHANGE = 4'd6;
	localparam logic [STATE_W-1:0] ST_LOCKOUT = 4'd7;

	////////////////////
	// display codes, 0 to 15 are hex digits
	localparam int DISP_W = 5;
	localparam logic [DISP_W-1:0] GL_BLANK = 5'd16;
	localparam logic [DISP_W-1:0] GL_DASH = 5'd17;
	localparam logic [DISP_W-1:0] GL_O = 5'd18;
	localparam logic [DISP_W-1:0] GL_P = 5'd19;
	localparam logic [DISP_W-1:0] GL_E = 5'd20;
	localparam logic [DISP_W-1:0] GL_N = 5'd21;
	localparam logic [DISP_W-1:0] GL_C = 5'd22;
	localparam logic [DISP_W-1:0] GL_L = 5'd23;
	localparam logic [DISP_W-1:0] GL_S = 5'd24;
	localparam logic [DISP_W-1:0] GL_D = 5'd25;

endpackage
